/* common/debug_pkg.sv */
// debugger package: byte and address types, opcode and engine state enums, identifier byte
package debug_pkg;

  // one SPI or memory byte
  typedef logic [7:0] data_t;

  // full debugger address as seen by the host
  typedef logic [15:0] addr_t;

  // opcodes sent as the first byte of a frame
  typedef enum logic [7:0]
  {
    CMD_READ  = 8'd1,  // addr hi, addr lo, count, then data out
    CMD_WRITE = 8'd2,  // addr hi, addr lo, then data in until cs rises
    CMD_PING  = 8'd3   // identifier in the second byte
  } cmd_e;

  // command engine decode states
  typedef enum logic [2:0]
  {
    ST_OPCODE,   // waiting for the first byte of a frame
    ST_ADDR_HI,
    ST_ADDR_LO,
    ST_COUNT,    // read length
    ST_READ,     // streaming memory bytes out
    ST_WRITE,    // storing incoming bytes
    ST_PING,     // identifier queued, rest of frame is don't care
    ST_IGNORE    // unknown opcode, wait for cs to rise
  } eng_state_e;

  // identifier returned by PING
  localparam data_t DEBUG_ID = 8'h65;

endpackage

/* common/byte_if.sv */
// byte stream between the SPI peripheral and the command engine
`timescale 1ns/1ps

interface byte_if;
  import debug_pkg::*;

  data_t rx_byte;  // last byte shifted in from the host
  logic  rx_dv;    // one-cycle strobe, rx_byte is complete
  data_t tx_byte;  // next byte to shift out
  logic  tx_dv;    // one-cycle strobe, queue tx_byte

  modport periph
  (
    output rx_byte,
    output rx_dv,
    input  tx_byte,
    input  tx_dv
  );

  modport engine
  (
    input  rx_byte,
    input  rx_dv,
    output tx_byte,
    output tx_dv
  );

endinterface

/* common/mem_if.sv */
// memory request and read data path between the command engine and the debug memory
`timescale 1ns/1ps

interface mem_if #(
  parameter int MEM_ADDR_W = 12
);
  import debug_pkg::*;

  logic [MEM_ADDR_W-1:0] addr;   // low bits of the debugger address
  logic                  en;     // access this cycle
  logic                  we;     // write when set, read otherwise
  data_t                 wdata;
  data_t                 rdata;  // valid one cycle after a read

  modport master
  (
    output addr,
    output en,
    output we,
    output wdata,
    input  rdata
  );

  modport slave
  (
    input  addr,
    input  en,
    input  we,
    input  wdata,
    output rdata
  );

endinterface

/* spi/spi_peripheral.sv */
// SPI mode 0 byte peripheral: pin synchronizer, receive deserializer and transmit serializer
`timescale 1ns/1ps

module spi_peripheral (
  input  logic   i_clk,
  input  logic   i_reset,
  input  logic   i_spi_clk,
  input  logic   i_spi_cs_n,
  input  logic   i_spi_copi,
  output logic   o_spi_cipo,
  byte_if.periph bus,
  output logic   o_frame_active
);
  import debug_pkg::*;

  logic [1:0] clk_sync;    // [1] is the usable level
  logic [1:0] cs_sync;
  logic [1:0] copi_sync;
  logic       clk_prev;    // for edge detect
  logic       cs_prev;

  logic       spi_rise;
  logic       spi_fall;
  logic       frame_active;
  logic       frame_start;
  logic       load_tx;     // byte boundary on the transmit side

  logic [2:0] rx_cnt;
  data_t      rx_shift;
  logic       rx_dv_q;

  logic [2:0] tx_cnt;
  data_t      tx_shift;
  data_t      tx_pending;  // byte queued by the engine

  // two-flop synchronizer plus one stage for edge detection
  always_ff @(posedge i_clk)
  begin
    if (i_reset)
    begin
      clk_sync  <= 2'b00;
      cs_sync   <= 2'b11;  // idle, no frame
      copi_sync <= 2'b00;
      clk_prev  <= 1'b0;
      cs_prev   <= 1'b1;
    end
    else
    begin
      clk_sync  <= {clk_sync[0], i_spi_clk};
      cs_sync   <= {cs_sync[0], i_spi_cs_n};
      copi_sync <= {copi_sync[0], i_spi_copi};
      clk_prev  <= clk_sync[1];
      cs_prev   <= cs_sync[1];
    end
  end

  assign spi_rise     = clk_sync[1] & ~clk_prev;
  assign spi_fall     = ~clk_sync[1] & clk_prev;
  assign frame_active = ~cs_sync[1];
  assign frame_start  = frame_active & cs_prev;  // cs just went low
  assign load_tx      = frame_start | (spi_fall & (tx_cnt == 3'd7));

  // receive: sample copi on rising edges, MSB first
  always_ff @(posedge i_clk)
  begin
    if (i_reset || !frame_active)
    begin
      rx_cnt  <= 3'd0;
      rx_dv_q <= 1'b0;
    end
    else
    begin
      rx_dv_q <= 1'b0;
      if (spi_rise)
      begin
        rx_shift <= {rx_shift[6:0], copi_sync[1]};
        rx_cnt   <= rx_cnt + 3'd1;
        if (rx_cnt == 3'd7)
          rx_dv_q <= 1'b1;  // byte complete in rx_shift next cycle
      end
    end
  end

  // transmit: new byte at each boundary, shift on falling edges
  always_ff @(posedge i_clk)
  begin
    if (i_reset || !frame_active)
    begin
      tx_cnt     <= 3'd0;
      tx_shift   <= 8'h00;
      tx_pending <= 8'h00;
    end
    else
    begin
      if (load_tx)
      begin
        tx_shift <= tx_pending;  // MSB goes out right away
        tx_cnt   <= 3'd0;
      end
      else if (spi_fall)
      begin
        tx_shift <= {tx_shift[6:0], 1'b0};
        tx_cnt   <= tx_cnt + 3'd1;
      end

      if (bus.tx_dv)
        tx_pending <= bus.tx_byte;
      else if (load_tx)
        tx_pending <= 8'h00;  // nothing queued sends zeros
    end
  end

  assign bus.rx_byte    = rx_shift;
  assign bus.rx_dv      = rx_dv_q;
  assign o_spi_cipo     = tx_shift[7];
  assign o_frame_active = frame_active;

endmodule

/* debugger/debug_cmd_engine.sv */
// command engine: decodes debugger frames, issues memory accesses and queues response bytes
`timescale 1ns/1ps

module debug_cmd_engine #(
  parameter int MEM_ADDR_W = 12
) (
  input  logic   i_clk,
  input  logic   i_reset,
  input  logic   i_frame_active,
  byte_if.engine bus,
  mem_if.master  mem
);
  import debug_pkg::*;

  eng_state_e            state_q;
  cmd_e                  cmd_q;       // READ or WRITE while in the address states
  addr_t                 addr_q;      // next address to access
  data_t                 count_q;     // reads still to issue

  logic [MEM_ADDR_W-1:0] mem_addr_q;
  data_t                 wdata_q;
  logic                  en_q;
  logic                  we_q;

  logic                  rd_pend_q;   // read data arrives this cycle
  logic                  ping_q;

  cmd_e                  rx_cmd;
  data_t                 count_src;
  logic                  rd_phase;
  logic                  rd_issue;
  logic                  wr_issue;

  assign rx_cmd = cmd_e'(bus.rx_byte);

  // in ST_COUNT the count byte itself starts the first read
  assign count_src = (state_q == ST_COUNT) ? bus.rx_byte : count_q;
  assign rd_phase  = bus.rx_dv & ((state_q == ST_COUNT) | (state_q == ST_READ));
  assign rd_issue  = rd_phase & (count_src != 8'd0);
  assign wr_issue  = bus.rx_dv & (state_q == ST_WRITE);

  // decode FSM and access strobes
  always_ff @(posedge i_clk)
  begin
    if (i_reset || !i_frame_active)
    begin
      state_q   <= ST_OPCODE;
      en_q      <= 1'b0;
      we_q      <= 1'b0;
      rd_pend_q <= 1'b0;
      ping_q    <= 1'b0;
    end
    else
    begin
      en_q      <= rd_issue | wr_issue;
      we_q      <= wr_issue;
      rd_pend_q <= en_q & ~we_q;
      ping_q    <= bus.rx_dv & (state_q == ST_OPCODE) & (rx_cmd == CMD_PING);

      if (bus.rx_dv)
      begin
        case (state_q)
          ST_OPCODE:
            case (rx_cmd)
              CMD_READ, CMD_WRITE: state_q <= ST_ADDR_HI;
              CMD_PING:            state_q <= ST_PING;
              default:             state_q <= ST_IGNORE;
            endcase
          ST_ADDR_HI: state_q <= ST_ADDR_LO;
          ST_ADDR_LO: state_q <= (cmd_q == CMD_READ) ? ST_COUNT : ST_WRITE;
          ST_COUNT:   state_q <= ST_READ;
          default:    state_q <= state_q;  // data states hold until cs rises
        endcase
      end
    end
  end

  // address, count and write data
  always_ff @(posedge i_clk)
  begin
    if (bus.rx_dv)
    begin
      case (state_q)
        ST_OPCODE:  cmd_q        <= rx_cmd;
        ST_ADDR_HI: addr_q[15:8] <= bus.rx_byte;
        ST_ADDR_LO: addr_q[7:0]  <= bus.rx_byte;
        default:    cmd_q        <= cmd_q;
      endcase
    end

    if (rd_phase)
      count_q <= rd_issue ? count_src - 8'd1 : 8'd0;

    if (rd_issue || wr_issue)
    begin
      mem_addr_q <= addr_q[MEM_ADDR_W-1:0];  // memory only sees the low bits
      addr_q     <= addr_q + 16'd1;          // wraps at the top of the 16-bit space
    end

    if (wr_issue)
      wdata_q <= bus.rx_byte;
  end

  assign mem.addr  = mem_addr_q;
  assign mem.en    = en_q;
  assign mem.we    = we_q;
  assign mem.wdata = wdata_q;

  // response stage: read data or identifier goes straight to the tx queue
  assign bus.tx_dv   = rd_pend_q | ping_q;
  assign bus.tx_byte = ping_q ? DEBUG_ID : mem.rdata;

endmodule

/* verilog/debug_memory.sv */
// single-port synchronous byte memory with one cycle read latency
`timescale 1ns/1ps

module debug_memory #(
  parameter int MEM_ADDR_W = 12
) (
  input  logic  i_clk,
  mem_if.slave  mem
);
  import debug_pkg::*;

  localparam int DEPTH = 2 ** MEM_ADDR_W;

  data_t ram [DEPTH];  // contents are not cleared by reset
  data_t rdata_q;

  always_ff @(posedge i_clk)
  begin
    if (mem.en)
    begin
      if (mem.we)
        ram[mem.addr] <= mem.wdata;
      else
        rdata_q <= ram[mem.addr];  // registered read
    end
  end

  assign mem.rdata = rdata_q;

endmodule

/* verilog/debugger_top.sv */
// debugger top level: SPI peripheral, command engine and debug memory
`timescale 1ns/1ps

module debugger_top #(
  parameter int MEM_ADDR_W = 12
) (
  input  logic i_clk,
  input  logic i_reset,

  // SPI pins, mode 0
  input  logic i_spi_cs_n,
  input  logic i_spi_clk,   // from the host
  input  logic i_spi_copi,
  output logic o_spi_cipo   // plain output, no tri-state here
);

  logic frame_active;  // synchronized, inverted chip select

  byte_if bytes ();
  mem_if #(
    .MEM_ADDR_W(MEM_ADDR_W)
  ) mem_bus ();

  spi_peripheral spi (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_spi_clk      (i_spi_clk),
    .i_spi_cs_n     (i_spi_cs_n),
    .i_spi_copi     (i_spi_copi),
    .o_spi_cipo     (o_spi_cipo),
    .bus            (bytes.periph),
    .o_frame_active (frame_active)
  );

  debug_cmd_engine #(
    .MEM_ADDR_W(MEM_ADDR_W)
  ) engine (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_frame_active (frame_active),  // frame end returns the engine to idle
    .bus            (bytes.engine),
    .mem            (mem_bus.master)
  );

  debug_memory #(
    .MEM_ADDR_W(MEM_ADDR_W)
  ) memory (
    .i_clk (i_clk),
    .mem   (mem_bus.slave)
  );

endmodule

/* tb/debugger_checker.sv */
// assertions on the command engine byte strobes and memory enable
`timescale 1ns/1ps

module debugger_checker (
  input logic i_clk,
  input logic i_reset,
  input logic i_frame_active,
  input logic i_rx_dv,
  input logic i_tx_dv,
  input logic i_mem_en
);

  // at most one queued response byte per cycle pair
  tx_dv_single: assert property (@(posedge i_clk) disable iff (i_reset)
    i_tx_dv |=> !i_tx_dv)
    else $error("tx_dv high for two cycles in a row");

  mem_en_in_frame: assert property (@(posedge i_clk) disable iff (i_reset)
    !i_frame_active |-> !i_mem_en)
    else $error("memory enable high outside a frame");

  rx_dv_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
    i_rx_dv |=> !i_rx_dv)  // one strobe per received byte
    else $error("rx_dv longer than one cycle");

endmodule

bind debug_cmd_engine debugger_checker chk (
  .i_clk          (i_clk),
  .i_reset        (i_reset),
  .i_frame_active (i_frame_active),
  .i_rx_dv        (bus.rx_dv),
  .i_tx_dv        (bus.tx_dv),
  .i_mem_en       (mem.en)
);

/* tb/debugger_tb.sv */
// testbench for the SPI memory debugger with host frames, a reference memory model and byte checks
`timescale 1ns/1ps

module debugger_tb;
  import debug_pkg::*;

  localparam int MEM_ADDR_W     = 12;
  localparam int MEM_SIZE       = 1 << MEM_ADDR_W;
  localparam int SPI_HALF       = 4;      // i_clk cycles per SPI half period
  localparam int CS_GAP         = 8;      // idle cycles between frames
  localparam int TIMEOUT_CYCLES = 70000;  // about 700 bytes of 64 cycles plus margin
  localparam int KIND_READ      = 0;
  localparam int KIND_ID        = 1;
  localparam int KIND_IDLE      = 2;
  localparam data_t PING_ID     = 8'h65;  // identifier the host expects from PING

  logic        clk = 1'b0;
  logic        reset;
  logic        spi_cs_n;
  logic        spi_clk;
  logic        spi_copi;
  logic        spi_cipo;

  data_t       ref_mem [MEM_SIZE];      // mirrors every host write
  logic [31:0] lcg_state = 32'd94;
  int          cycle_count = 0;
  data_t       got_q [$];               // returned bytes waiting for the compare process
  data_t       exp_q [$];
  int          kind_q [$];

  debugger_top #(
    .MEM_ADDR_W(MEM_ADDR_W)
  ) uut (
    .i_clk      (clk),
    .i_reset    (reset),
    .i_spi_cs_n (spi_cs_n),
    .i_spi_clk  (spi_clk),
    .i_spi_copi (spi_copi),
    .o_spi_cipo (spi_cipo)
  );

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout: tests did not finish");
      abort_run();
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // modelled byte at the host address taken modulo the memory size
  function automatic data_t expected_read(addr_t addr);
    logic [MEM_ADDR_W-1:0] idx;
    idx = MEM_ADDR_W'(int'(addr) % MEM_SIZE);
    return ref_mem[idx];
  endfunction

  task automatic write_model(addr_t addr, data_t data);
    logic [MEM_ADDR_W-1:0] idx;
    idx = MEM_ADDR_W'(int'(addr) % MEM_SIZE);
    ref_mem[idx] = data;
  endtask

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_read(data_t got, data_t exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t: read byte %02h, expected %02h", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_id(data_t got);
    if (got !== PING_ID)
    begin
      $display("FAILED at %0t: ping returned %02h, expected %02h", $time, got, PING_ID);
      abort_run();
    end
  endtask

  task automatic check_idle(data_t got);
    if (got !== 8'h00)
    begin
      $display("FAILED at %0t: idle byte %02h, expected 00", $time, got);
      abort_run();
    end
  endtask

  // one mode 0 byte MSB first with cipo sampled at each rising SPI edge
  task automatic spi_byte(input data_t tx, output data_t rx);
    for (int i = 7; i >= 0; i--)
    begin
      spi_copi = tx[i];
      repeat (SPI_HALF) @(negedge clk);
      spi_clk = 1'b1;
      rx[i] = spi_cipo;
      repeat (SPI_HALF) @(negedge clk);
      spi_clk = 1'b0;
    end
  endtask

  task automatic send_and_check(data_t tx, int kind, data_t exp);
    data_t rx;
    spi_byte(tx, rx);
    got_q.push_back(rx);
    exp_q.push_back(exp);
    kind_q.push_back(kind);
  endtask

  task automatic end_frame();
    spi_cs_n = 1'b1;
    spi_copi = 1'b0;
    repeat (CS_GAP) @(negedge clk);
  endtask

  task automatic ping_frame();
    spi_cs_n = 1'b0;
    send_and_check(data_t'(CMD_PING), KIND_IDLE, 8'h00);
    send_and_check(8'h00, KIND_ID, PING_ID);  // identifier in byte 2
    send_and_check(8'h00, KIND_IDLE, 8'h00);
    end_frame();
  endtask

  task automatic write_frame(addr_t addr, int len);
    data_t d;
    spi_cs_n = 1'b0;
    send_and_check(data_t'(CMD_WRITE), KIND_IDLE, 8'h00);
    send_and_check(addr[15:8], KIND_IDLE, 8'h00);
    send_and_check(addr[7:0], KIND_IDLE, 8'h00);
    for (int k = 0; k < len; k++)
    begin
      d = data_t'(next_rand() >> 16);
      send_and_check(d, KIND_IDLE, 8'h00);
      write_model(addr + addr_t'(k), d);
    end
    end_frame();
  endtask

  // header bytes 1 to 4 come back as zero and data starts with byte 5
  task automatic read_frame(addr_t addr, int count);
    spi_cs_n = 1'b0;
    send_and_check(data_t'(CMD_READ), KIND_IDLE, 8'h00);
    send_and_check(addr[15:8], KIND_IDLE, 8'h00);
    send_and_check(addr[7:0], KIND_IDLE, 8'h00);
    send_and_check(data_t'(count), KIND_IDLE, 8'h00);
    for (int k = 0; k < count; k++)
      send_and_check(8'h00, KIND_READ, expected_read(addr + addr_t'(k)));
    end_frame();
  endtask

  task automatic read_cut_frame(addr_t addr);
    spi_cs_n = 1'b0;
    send_and_check(data_t'(CMD_READ), KIND_IDLE, 8'h00);
    send_and_check(addr[15:8], KIND_IDLE, 8'h00);
    send_and_check(addr[7:0], KIND_IDLE, 8'h00);
    end_frame();  // cut before the count byte
  endtask

  task automatic unknown_frame(addr_t addr);
    spi_cs_n = 1'b0;
    send_and_check(8'hA7, KIND_IDLE, 8'h00);
    send_and_check(addr[15:8], KIND_IDLE, 8'h00);
    send_and_check(addr[7:0], KIND_IDLE, 8'h00);
    send_and_check(8'h5A, KIND_IDLE, 8'h00);
    send_and_check(8'hC3, KIND_IDLE, 8'h00);
    end_frame();
  endtask

  // compare process draining returned bytes as they arrive
  initial
  begin
    data_t got;
    data_t exp;
    int    kind;
    forever
    begin
      @(posedge clk);
      while (got_q.size() > 0)
      begin
        got  = got_q.pop_front();
        exp  = exp_q.pop_front();
        kind = kind_q.pop_front();
        case (kind)
          KIND_READ: check_read(got, exp);
          KIND_ID:   check_id(got);
          default:   check_idle(got);
        endcase
      end
    end
  end

  initial
  begin
    addr_t addr;
    int    len;
    reset    = 1'b1;
    spi_cs_n = 1'b1;
    spi_clk  = 1'b0;
    spi_copi = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    repeat (CS_GAP) @(negedge clk);

    ping_frame();

    for (int n = 0; n < 20; n++)
    begin
      addr = addr_t'(next_rand() >> 12);
      len  = 1 + int'((next_rand() >> 16) % 32'd16);
      write_frame(addr, len);
      read_frame(addr, len);
    end

    // write across the top of the 16-bit space and read back through an alias 4096 lower
    write_frame(16'hFFFC, 8);
    read_frame(16'hEFFC, 8);
    read_frame(16'hFFFC, 8);

    read_cut_frame(16'hFFFC);
    unknown_frame(16'hFFFC);
    read_frame(16'hEFFC, 8);  // contents must be unchanged
    ping_frame();

    while (got_q.size() != 0)
      @(posedge clk);
    @(negedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* tb.f */
common/debug_pkg.sv
common/byte_if.sv
common/mem_if.sv
spi/spi_peripheral.sv
debugger/debug_cmd_engine.sv
verilog/debug_memory.sv
verilog/debugger_top.sv
tb/debugger_checker.sv
tb/debugger_tb.sv

/* Makefile */
# Verilator build and run of the debugger testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module debugger_tb -f tb.f -o debugger_sim
	./obj_dir/debugger_sim | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null

clean:
	rm -rf obj_dir
